// ==== flist.f ====
+incdir+.
bp_pkg.sv
inst_classifier.sv
branch_target_buffer.sv
local_history_predictor.sv
prediction_merge.sv
branch_predict_unit.sv
tb_clock_gen.sv
branch_predict_unit_assert.sv
branch_predict_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= branch_predict_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_STR  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# output is kept in a shell variable and searched for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_STR)'

clean:
	rm -rf $(OBJ_DIR)

// ==== branch_predict_unit_tb.sv ====
`timescale 1ns/1ns
`include "bp_defines.svh"

module branch_predict_unit_tb;

  typedef enum logic {
    ROW_LOOKUP,
    ROW_RESOLVE
  } row_op_e;

  typedef struct packed {
    row_op_e             op;
    logic                rand_fill; // word comes from $urandom
    logic [`BP_XLEN-1:0] inst;
    logic                taken;
    logic [`BP_XLEN-1:0] target;
    logic                exp_hit;
    logic                exp_taken;
    logic [`BP_XLEN-1:0] exp_target;
  } row_t;

  // rv32 opcodes
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_ALU    = 7'b0110011;

  // keys, bits 31..8 of the word
  localparam logic [`BP_KEY_W-1:0] KEY_B1 = 24'h000302; // lht row 2, idx 2
  localparam logic [`BP_KEY_W-1:0] KEY_J1 = 24'h00a405; // idx 5
  localparam logic [`BP_KEY_W-1:0] KEY_J1_ALIAS = 24'h01a405; // idx 5, other tag
  localparam logic [`BP_KEY_W-1:0] KEY_J2 = 24'h000412; // lht row 2, idx 18

  logic                clk;
  logic                rst;
  bp_pkg::lookup_req_t lookup;
  bp_pkg::resolve_t    resolve;
  bp_pkg::prediction_t prediction;

  row_t rows [$];
  int   n_rows;
  int   n_checks;
  int   valid_errs;
  int   hit_errs;
  int   taken_errs;
  int   target_errs;
  int   assert_errs;
  int   total_errs;

  tb_clock_gen tb_clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  branch_predict_unit branch_predict_unit_i (
    .clk        (clk),
    .rst        (rst),
    .lookup     (lookup),
    .resolve    (resolve),
    .prediction (prediction)
  );

  task automatic add_lookup(
    input logic [`BP_KEY_W-1:0] key,
    input logic [6:0]           opc,
    input logic                 exp_hit,
    input logic                 exp_taken,
    input logic [`BP_XLEN-1:0]  exp_target
  );
    row_t r;
    r            = '0;
    r.op         = ROW_LOOKUP;
    r.inst       = {key, 1'b0, opc};
    r.exp_hit    = exp_hit;
    r.exp_taken  = exp_taken;
    r.exp_target = exp_target;
    rows.push_back(r);
  endtask

  task automatic add_resolve(
    input logic [`BP_KEY_W-1:0] key,
    input logic [6:0]           opc,
    input logic                 taken,
    input logic [`BP_XLEN-1:0]  target
  );
    row_t r;
    r        = '0;
    r.op     = ROW_RESOLVE;
    r.inst   = {key, 1'b0, opc};
    r.taken  = taken;
    r.target = target;
    rows.push_back(r);
  endtask

  // non-control word, never predicted
  task automatic noise_lookup();
    row_t r;
    r           = '0;
    r.op        = ROW_LOOKUP;
    r.rand_fill = 1'b1;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // cold tables
    add_lookup(24'h123401, OPC_BRANCH, 1'b0, 1'b0, 32'h0);
    add_lookup(24'h000005, OPC_JAL, 1'b0, 1'b0, 32'h0);
    noise_lookup();
    // jal learned, then same index with another tag misses
    add_resolve(KEY_J1, OPC_JAL, 1'b1, 32'h0000_4000);
    add_lookup(KEY_J1, OPC_JAL, 1'b1, 1'b1, 32'h0000_4000);
    add_lookup(KEY_J1_ALIAS, OPC_JAL, 1'b0, 1'b0, 32'h0);
    // first taken moves history 0000 -> 1000, counter there still 0
    add_resolve(KEY_B1, OPC_BRANCH, 1'b1, 32'h0000_1000);
    add_lookup(KEY_B1, OPC_BRANCH, 1'b1, 1'b0, 32'h0000_1000);
    // history fills to 1111, then counter 15 climbs to 2
    repeat (5) add_resolve(KEY_B1, OPC_BRANCH, 1'b1, 32'h0000_1000);
    add_lookup(KEY_B1, OPC_BRANCH, 1'b1, 1'b1, 32'h0000_1000);
    repeat (2) add_resolve(KEY_B1, OPC_BRANCH, 1'b1, 32'h0000_1000); // sits at 3
    add_lookup(KEY_B1, OPC_BRANCH, 1'b1, 1'b1, 32'h0000_1000);
    // not taken, counter 15 back to 2 and history 0111
    add_resolve(KEY_B1, OPC_BRANCH, 1'b0, 32'h0000_1000);
    add_lookup(KEY_B1, OPC_BRANCH, 1'b1, 1'b0, 32'h0000_1000);
    repeat (4) add_resolve(KEY_B1, OPC_BRANCH, 1'b1, 32'h0000_1000);
    add_lookup(KEY_B1, OPC_BRANCH, 1'b1, 1'b1, 32'h0000_1000); // counter 15 at 2
    // alu word carrying the learned branch key
    add_lookup(KEY_B1, OPC_ALU, 1'b0, 1'b0, 32'h0);
    // jalr shares lht row 2 with the branch
    add_lookup(KEY_J2, OPC_JALR, 1'b0, 1'b0, 32'h0);
    add_resolve(KEY_J2, OPC_JALR, 1'b1, 32'h0000_8000);
    add_lookup(KEY_J2, OPC_JALR, 1'b1, 1'b1, 32'h0000_8000);
    add_resolve(KEY_J2, OPC_JALR, 1'b0, 32'h0000_8000);
    add_lookup(KEY_B1, OPC_BRANCH, 1'b1, 1'b1, 32'h0000_1000);
    add_lookup(KEY_J2, OPC_JALR, 1'b1, 1'b1, 32'h0000_8000);
  endtask

  task automatic check_prediction(input int idx, input row_t r);
    n_checks++;
    if (prediction.valid !== 1'b1)
    begin
      valid_errs++;
      $display("ERROR %0t: row %0d prediction valid not high after lookup", $time, idx);
    end
    if (prediction.hit !== r.exp_hit)
    begin
      hit_errs++;
      $display("ERROR %0t: row %0d hit %b expected %b",
               $time, idx, prediction.hit, r.exp_hit);
    end
    if (prediction.taken !== r.exp_taken)
    begin
      taken_errs++;
      $display("ERROR %0t: row %0d taken %b expected %b",
               $time, idx, prediction.taken, r.exp_taken);
    end
    if (prediction.target !== r.exp_target)
    begin
      target_errs++;
      $display("ERROR %0t: row %0d target %h expected %h",
               $time, idx, prediction.target, r.exp_target);
    end
  endtask

  // one cycle of drive, then four idle cycles
  task automatic apply_row(input int idx);
    row_t                r;
    logic [`BP_XLEN-1:0] inst;
    bp_pkg::lookup_req_t req;
    bp_pkg::resolve_t    res;
    r    = rows[idx];
    inst = r.inst;
    if (r.rand_fill)
    begin
      inst      = $urandom();
      inst[6:0] = OPC_ALU;
    end
    req = '0;
    res = '0;
    @(posedge clk);
    if (r.op == ROW_LOOKUP)
    begin
      req.valid = 1'b1;
      req.inst  = inst;
      lookup <= req;
    end
    else
    begin
      res.valid  = 1'b1;
      res.inst   = inst;
      res.taken  = r.taken;
      res.target = r.target;
      resolve <= res;
    end
    @(posedge clk); // dut takes the request here
    lookup  <= '0;
    resolve <= '0;
    repeat (2) @(posedge clk);
    @(negedge clk); // prediction settled after the third edge
    if (r.op == ROW_LOOKUP)
      check_prediction(idx, r);
    @(posedge clk);
  endtask

  initial
  begin
    lookup      <= '0;
    resolve     <= '0;
    n_checks    = 0;
    valid_errs  = 0;
    hit_errs    = 0;
    taken_errs  = 0;
    target_errs = 0;
    assert_errs = 0;
    void'($urandom(85001));
    build_table();
    n_rows = rows.size();
    @(negedge rst);
    repeat (2) @(posedge clk);
    for (int i = 0; i < n_rows; i++)
      apply_row(i);
    assert_errs = branch_predict_unit_i.branch_predict_unit_assert_i.fail_count;
    total_errs = valid_errs + hit_errs + taken_errs + target_errs + assert_errs;
    $display("checks %0d, errors: valid %0d hit %0d taken %0d target %0d assert %0d",
             n_checks, valid_errs, hit_errs, taken_errs, target_errs, assert_errs);
    if (total_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // limit scales with the table length
  initial
  begin
    wait (n_rows > 0);
    #((n_rows * 5 + 16 + 50) * 8);
    $display("watchdog: the run timed out before all rows were applied");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== branch_predict_unit_assert.sv ====
`timescale 1ns/1ns

module branch_predict_unit_assert (
  input logic                clk,
  input logic                rst,
  input bp_pkg::lookup_req_t lookup,
  input bp_pkg::prediction_t prediction
);

  int fail_count = 0; // failed assertions so far

  // a taken prediction always comes with a btb hit
  taken_needs_hit: assert property (@(posedge clk) disable iff (rst)
    prediction.taken |-> prediction.hit)
    else
    begin
      fail_count++;
      $error("prediction taken without a btb hit");
    end

  // fixed three cycle lookup latency
  valid_latency: assert property (@(posedge clk) disable iff (rst)
    prediction.valid == $past(lookup.valid, 3))
    else
    begin
      fail_count++;
      $error("prediction valid does not follow lookup valid by 3 cycles");
    end

  quiet_in_reset: assert property (@(posedge clk)
    rst |-> !prediction.valid)
    else
    begin
      fail_count++;
      $error("prediction valid high during reset");
    end

endmodule

bind branch_predict_unit branch_predict_unit_assert branch_predict_unit_assert_i (
  .clk        (clk),
  .rst        (rst),
  .lookup     (lookup),
  .prediction (prediction)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 4; // 8 ns clock
  localparam int RST_CYCLES  = 16;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== branch_predict_unit.sv ====
`timescale 1ns/1ns
`include "bp_defines.svh"

module branch_predict_unit (
  input  logic                clk,
  input  logic                rst,
  input  bp_pkg::lookup_req_t lookup,
  input  bp_pkg::resolve_t    resolve,
  output bp_pkg::prediction_t prediction
);

  bp_pkg::tbl_read_t   rd;
  bp_pkg::tbl_write_t  wr;
  logic                btb_hit;
  logic [`BP_XLEN-1:0] btb_target;
  logic                predict_taken;

  inst_classifier inst_classifier_i (
    .clk     (clk),
    .rst     (rst),
    .lookup  (lookup),
    .resolve (resolve),
    .rd      (rd),
    .wr      (wr)
  );

  branch_target_buffer branch_target_buffer_i (
    .rd         (rd),
    .wr         (wr),
    .clk        (clk),
    .rst        (rst),
    .btb_hit    (btb_hit),
    .btb_target (btb_target)
  );

  local_history_predictor local_history_predictor_i (
    .clk           (clk),
    .rst           (rst),
    .rd            (rd),
    .wr            (wr),
    .predict_taken (predict_taken)
  );

  // final stage, third cycle after the lookup
  prediction_merge prediction_merge_i (
    .clk           (clk),
    .rst           (rst),
    .rd            (rd),
    .btb_hit       (btb_hit),
    .btb_target    (btb_target),
    .predict_taken (predict_taken),
    .prediction    (prediction)
  );

endmodule

// ==== prediction_merge.sv ====
`timescale 1ns/1ns
`include "bp_defines.svh"

module prediction_merge (
  input  logic                clk,
  input  logic                rst,
  input  bp_pkg::tbl_read_t   rd,
  input  logic                btb_hit,
  input  logic [`BP_XLEN-1:0] btb_target,
  input  logic                predict_taken,
  output bp_pkg::prediction_t prediction
);

  logic                vld_q;
  bp_pkg::inst_class_e cls_q; // lines up with the table outputs
  logic                hit;
  logic                taken;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      vld_q <= 1'b0;
    else
      vld_q <= rd.valid;
  end

  always_ff @(posedge clk)
  begin
    cls_q <= rd.cls;
  end

  assign hit = (cls_q != bp_pkg::CLASS_NONE) && btb_hit;

  always_comb
  begin
    case (cls_q)
      bp_pkg::CLASS_COND_BRANCH: taken = hit && predict_taken;
      bp_pkg::CLASS_JAL,
      bp_pkg::CLASS_JALR:        taken = hit; // jumps always go
      default:                   taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      prediction <= '0;
    else
    begin
      prediction.valid  <= vld_q;
      prediction.hit    <= hit;
      prediction.taken  <= taken;
      prediction.target <= hit ? btb_target : '0;
    end
  end

endmodule

// ==== local_history_predictor.sv ====
`timescale 1ns/1ns
`include "bp_defines.svh"

module local_history_predictor (
  input  logic               clk,
  input  logic               rst,
  input  bp_pkg::tbl_read_t  rd,
  input  bp_pkg::tbl_write_t wr,
  output logic               predict_taken
);

  localparam int ROWS  = 1 << `BP_LHT_IDX_W;
  localparam int CNTS  = 1 << `BP_HIST_W;
  localparam logic [`BP_CNT_W-1:0] CNT_MAX = '1;

  logic [`BP_HIST_W-1:0] lht [ROWS]; // local history per row
  logic [`BP_CNT_W-1:0]  pht [CNTS]; // shared pattern counters

  logic [`BP_LHT_IDX_W-1:0] rd_row;
  logic [`BP_HIST_W-1:0]    rd_hist;
  logic [`BP_LHT_IDX_W-1:0] wr_row;
  logic [`BP_HIST_W-1:0]    wr_hist;
  logic [`BP_CNT_W-1:0]     wr_cnt;
  logic [`BP_CNT_W-1:0]     cnt_next;

  assign rd_row  = rd.key[`BP_LHT_IDX_W-1:0];
  assign rd_hist = lht[rd_row];
  assign wr_row  = wr.key[`BP_LHT_IDX_W-1:0];
  assign wr_hist = lht[wr_row];
  assign wr_cnt  = pht[wr_hist];

  always_comb
  begin
    cnt_next = wr_cnt;
    if (wr.taken && (wr_cnt != CNT_MAX))
      cnt_next = wr_cnt + 1'b1;
    else if (!wr.taken && (wr_cnt != '0))
      cnt_next = wr_cnt - 1'b1;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < ROWS; i++)
        lht[i] <= '0;
      for (int j = 0; j < CNTS; j++)
        pht[j] <= '0; // strongly not taken
      predict_taken <= 1'b0;
    end
    else
    begin
      if (wr.pred_we)
      begin
        pht[wr_hist] <= cnt_next;
        // newest outcome enters at the top
        lht[wr_row] <= {wr.taken, wr_hist[`BP_HIST_W-1:1]};
      end
      predict_taken <= rd.valid && pht[rd_hist][`BP_CNT_W-1]; // msb of counter
    end
  end

endmodule

// ==== branch_target_buffer.sv ====
`timescale 1ns/1ns
`include "bp_defines.svh"

module branch_target_buffer (
  input  bp_pkg::tbl_read_t  rd,
  input  bp_pkg::tbl_write_t wr,
  input  logic               clk,
  input  logic               rst,
  output logic               btb_hit,
  output logic [`BP_XLEN-1:0] btb_target
);

  localparam int DEPTH = 1 << `BP_BTB_IDX_W;

  logic [DEPTH-1:0]        entry_vld;
  logic [`BP_BTB_TAG_W-1:0] tag_mem [DEPTH];
  logic [`BP_XLEN-1:0]      target_mem [DEPTH];

  logic [`BP_BTB_IDX_W-1:0] rd_idx;
  logic [`BP_BTB_TAG_W-1:0] rd_tag;
  logic [`BP_BTB_IDX_W-1:0] wr_idx;
  logic [`BP_BTB_TAG_W-1:0] wr_tag;

  // index from the low key bits, tag from the top
  assign rd_idx = rd.key[`BP_BTB_IDX_W-1:0];
  assign rd_tag = rd.key[`BP_KEY_W-1 -: `BP_BTB_TAG_W];
  assign wr_idx = wr.key[`BP_BTB_IDX_W-1:0];
  assign wr_tag = wr.key[`BP_KEY_W-1 -: `BP_BTB_TAG_W];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      entry_vld <= '0;
      btb_hit   <= 1'b0;
    end
    else
    begin
      if (wr.btb_we)
        entry_vld[wr_idx] <= 1'b1;
      // compare uses the contents before this edge's write
      btb_hit <= rd.valid && entry_vld[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr.btb_we)
    begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= wr.target;
    end
  end

  // target is only meaningful with btb_hit, merge masks it otherwise
  always_ff @(posedge clk)
  begin
    if (rd.valid)
      btb_target <= target_mem[rd_idx];
  end

endmodule

// ==== inst_classifier.sv ====
`timescale 1ns/1ns
`include "bp_defines.svh"

module inst_classifier (
  input  logic                clk,
  input  logic                rst,
  input  bp_pkg::lookup_req_t lookup,
  input  bp_pkg::resolve_t    resolve,
  output bp_pkg::tbl_read_t   rd,
  output bp_pkg::tbl_write_t  wr
);

  logic                lookup_vld_q;
  logic [`BP_XLEN-1:0] lookup_inst_q;
  logic                res_vld_q;
  logic [`BP_XLEN-1:0] res_inst_q;
  logic                res_taken_q;
  logic [`BP_XLEN-1:0] res_target_q;

  function automatic bp_pkg::inst_class_e classify(input logic [6:0] opcode);
    bp_pkg::inst_class_e cls;
    case (opcode)
      bp_pkg::OP_BRANCH: cls = bp_pkg::CLASS_COND_BRANCH;
      bp_pkg::OP_JAL:    cls = bp_pkg::CLASS_JAL;
      bp_pkg::OP_JALR:   cls = bp_pkg::CLASS_JALR;
      default:           cls = bp_pkg::CLASS_NONE;
    endcase
    return cls;
  endfunction

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      lookup_vld_q <= 1'b0;
      res_vld_q    <= 1'b0;
    end
    else
    begin
      lookup_vld_q <= lookup.valid;
      res_vld_q    <= resolve.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    lookup_inst_q <= lookup.inst;
    res_inst_q    <= resolve.inst;
    res_taken_q   <= resolve.taken;
    res_target_q  <= resolve.target;
  end

  // key is the upper instruction bits, not the pc
  assign rd.valid = lookup_vld_q;
  assign rd.key   = lookup_inst_q[`BP_XLEN-1 -: `BP_KEY_W];
  assign rd.cls   = classify(lookup_inst_q[6:0]);

  assign wr.btb_we  = res_vld_q; // every resolve refreshes the btb entry
  assign wr.pred_we = res_vld_q &&
                      (classify(res_inst_q[6:0]) == bp_pkg::CLASS_COND_BRANCH);
  assign wr.key     = res_inst_q[`BP_XLEN-1 -: `BP_KEY_W];
  assign wr.taken   = res_taken_q;
  assign wr.target  = res_target_q;

endmodule

// ==== bp_pkg.sv ====
package bp_pkg;

  `include "bp_defines.svh"

  // control transfer opcodes, RV32 encoding
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [1:0] {
    CLASS_NONE,
    CLASS_COND_BRANCH,
    CLASS_JAL,
    CLASS_JALR
  } inst_class_e;

  typedef struct packed {
    logic                valid;
    logic [`BP_XLEN-1:0] inst;
  } lookup_req_t;

  // outcome from execute
  typedef struct packed {
    logic                valid;
    logic [`BP_XLEN-1:0] inst;
    logic                taken;
    logic [`BP_XLEN-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic                valid;
    logic                hit;
    logic                taken;
    logic [`BP_XLEN-1:0] target;
  } prediction_t;

  // read command to both tables
  typedef struct packed {
    logic                 valid;
    logic [`BP_KEY_W-1:0] key;
    inst_class_e          cls;
  } tbl_read_t;

  // write command, enables already decided
  typedef struct packed {
    logic                 btb_we;
    logic                 pred_we;
    logic [`BP_KEY_W-1:0] key;
    logic                 taken;
    logic [`BP_XLEN-1:0]  target;
  } tbl_write_t;

endpackage

// ==== bp_defines.svh ====
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// instruction word and target address width
`define BP_XLEN 32

// branch key is instruction bits 31..8
`define BP_KEY_W 24

// target buffer, index from key[5:0], tag from key[23:10]
`define BP_BTB_IDX_W 6
`define BP_BTB_TAG_W 14

// local predictor geometry
`define BP_LHT_IDX_W 4 // key[3:0] picks the history row
`define BP_HIST_W 4 // history also indexes the pattern table
`define BP_CNT_W 2 // saturating counter

`endif
